// File: addr_decoder.sv
/*
 * Address decoder: maps a request onto L2, boot ROM or control registers
 * and raises the request strobe of the block behind that target
 */

`include "mem_system_macros.svh"

module addr_decoder
  import mem_system_pkg::*;
(
  input  addr_t   addr_i,
  input  logic    req_i,
  output logic    l2_req_o,
  output logic    periph_req_o,
  output target_e tgt_o
);

  localparam int unsigned WordBytes = `MS_DATA_W / 8;

  // Region sizes in bytes
  localparam addr_t L2Size   = addr_t'(`MS_NUM_BANKS * `MS_BANK_WORDS * WordBytes);
  localparam addr_t RomSize  = addr_t'($size(BOOTROM_IMAGE) * WordBytes);
  localparam addr_t CtrlSize = addr_t'((2 ** $bits(ctrl_reg_e)) * WordBytes);

  // Unsigned offset compare, addresses below the base wrap and miss
  function automatic logic in_region(addr_t addr, addr_t base, addr_t size);
    addr_t offset;
    offset = addr - base;
    return offset < size;
  endfunction

  logic hit_l2;
  logic hit_rom;
  logic hit_ctrl;

  assign hit_l2   = in_region(addr_i, `MS_L2_BASE, L2Size);
  assign hit_rom  = in_region(addr_i, `MS_BOOTROM_BASE, RomSize);
  assign hit_ctrl = in_region(addr_i, `MS_CTRL_BASE, CtrlSize);

  // Regions do not overlap, the order only fixes a single result
  always_comb begin
    if (hit_l2) begin
      tgt_o = TGT_L2;
    end else if (hit_rom) begin
      tgt_o = TGT_BOOTROM;
    end else if (hit_ctrl) begin
      tgt_o = TGT_CTRL;
    end else begin
      tgt_o = TGT_NONE;
    end
  end

  assign l2_req_o     = req_i && (tgt_o == TGT_L2);
  assign periph_req_o = req_i && ((tgt_o == TGT_BOOTROM) || (tgt_o == TGT_CTRL)); // ROM or regs

endmodule : addr_decoder

// File: compile.f
+incdir+.
mem_system_pkg.sv
addr_decoder.sv
l2_banks.sv
periph_regs.sv
resp_mux.sv
mem_system.sv
mem_system_sva.sv
tb_mem_system.sv

// File: l2_banks.sv
/*
 * L2 memory: word-interleaved bank array with byte-enable writes
 * and read data registered one cycle after the request
 */

`include "mem_system_macros.svh"

module l2_banks
  import mem_system_pkg::*;
(
  input  logic  clk_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t strb_i,
  output data_t rdata_o
);

  localparam int unsigned WordLsb = $clog2(`MS_DATA_W / 8);
  localparam int unsigned RowLsb  = WordLsb + $bits(bank_idx_t);

  bank_idx_t                      bank_idx;
  bank_row_t                      bank_row;
  bank_idx_t                      bank_sel_q;  // Bank of the pending read
  logic      [`MS_NUM_BANKS-1:0]  bank_req;
  data_t     [`MS_NUM_BANKS-1:0]  bank_rdata;

  // Consecutive words go to consecutive banks
  assign bank_idx = addr_i[WordLsb +: $bits(bank_idx_t)];
  assign bank_row = addr_i[RowLsb +: $bits(bank_row_t)];

  for (genvar b = 0; b < `MS_NUM_BANKS; b++) begin : gen_banks
    data_t mem_q [`MS_BANK_WORDS];
    data_t rdata_q;

    assign bank_req[b] = req_i && (bank_idx == bank_idx_t'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req[b]) begin
        if (we_i) begin
          for (int unsigned i = 0; i < $bits(strb_t); i++) begin
            if (strb_i[i]) begin
              mem_q[bank_row][8*i +: 8] <= wdata_i[8*i +: 8]; // Enabled bytes only
            end
          end
        end else begin
          rdata_q <= mem_q[bank_row];
        end
      end
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Remember which bank answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      bank_sel_q <= bank_idx;
    end
  end

  assign rdata_o = bank_rdata[bank_sel_q];

endmodule : l2_banks

// File: mem_system.sv
/*
 * Memory system top: request port decoded onto the L2 banks and the
 * peripheral block, responses merged one cycle later
 */

`include "mem_system_macros.svh"

module mem_system
  import mem_system_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  // Request, accepted in the cycle it is presented
  input  logic                     req_i,
  input  logic                     we_i,
  input  addr_t                    addr_i,
  input  data_t                    wdata_i,
  input  strb_t                    strb_i,

  // Response, one cycle after the request
  output logic                     resp_valid_o,
  output data_t                    resp_rdata_o,
  output logic                     resp_err_o,

  // Side outputs
  output logic                     eoc_valid_o,
  output logic [`MS_NUM_CORES-1:0] wake_up_o
);

  logic    l2_req;
  logic    periph_req;
  target_e tgt;
  data_t   l2_rdata;
  data_t   periph_rdata;

  addr_decoder i_addr_decoder (
    .addr_i      (addr_i    ),
    .req_i       (req_i     ),
    .l2_req_o    (l2_req    ),
    .periph_req_o(periph_req),
    .tgt_o       (tgt       )
  );

  l2_banks i_l2_banks (
    .clk_i  (clk_i   ),
    .req_i  (l2_req  ),
    .we_i   (we_i    ),
    .addr_i (addr_i  ),
    .wdata_i(wdata_i ),
    .strb_i (strb_i  ),
    .rdata_o(l2_rdata)
  );

  periph_regs i_periph_regs (
    .clk_i      (clk_i              ),
    .reset_i    (reset_i            ),
    .req_i      (periph_req         ),
    .we_i       (we_i               ),
    .is_rom_i   (tgt == TGT_BOOTROM ), // ROM versus control registers
    .addr_i     (addr_i             ),
    .wdata_i    (wdata_i            ),
    .strb_i     (strb_i             ),
    .rdata_o    (periph_rdata       ),
    .eoc_valid_o(eoc_valid_o        ),
    .wake_up_o  (wake_up_o          )
  );

  resp_mux i_resp_mux (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .req_i         (req_i       ),
    .we_i          (we_i        ),
    .tgt_i         (tgt         ),
    .l2_rdata_i    (l2_rdata    ),
    .periph_rdata_i(periph_rdata),
    .resp_valid_o  (resp_valid_o),
    .resp_rdata_o  (resp_rdata_o),
    .resp_err_o    (resp_err_o  )
  );

endmodule : mem_system

// File: mem_system_macros.svh
/*
 * Memory system configuration: bus widths, L2 bank geometry and region bases
 */

`ifndef MEM_SYSTEM_MACROS_SVH
`define MEM_SYSTEM_MACROS_SVH

// Bus widths
`define MS_ADDR_W 32
`define MS_DATA_W 32

// L2 geometry, 4 banks x 64 words = 1 KiB
`define MS_NUM_BANKS  4
`define MS_BANK_WORDS 64

// Cores reached by the wake-up register
`define MS_NUM_CORES 4

// Region base addresses
`define MS_L2_BASE      32'h8000_0000 // L2, 1 KiB
`define MS_BOOTROM_BASE 32'hA000_0000 // Boot ROM, 8 words
`define MS_CTRL_BASE    32'h4000_0000 // Control block, 16 bytes

`endif

// File: mem_system_pkg.sv
/*
 * Memory system types: bus words, bank split, decode targets,
 * control register map and the boot image
 */

`include "mem_system_macros.svh"

package mem_system_pkg;

  // Bus words
  typedef logic [`MS_ADDR_W-1:0]   addr_t;
  typedef logic [`MS_DATA_W-1:0]   data_t;
  typedef logic [`MS_DATA_W/8-1:0] strb_t;

  // Word-interleaved split of an L2 address
  typedef logic [$clog2(`MS_NUM_BANKS)-1:0]  bank_idx_t; // addr[3:2]
  typedef logic [$clog2(`MS_BANK_WORDS)-1:0] bank_row_t; // addr[9:4]

  // Decode result, one per request
  typedef enum logic [1:0] {
    TGT_L2      = 2'd0,
    TGT_BOOTROM = 2'd1,
    TGT_CTRL    = 2'd2,
    TGT_NONE    = 2'd3
  } target_e;

  // Control register word offsets
  typedef enum logic [1:0] {
    REG_EOC       = 2'd0, // Read and write
    REG_WAKE_UP   = 2'd1, // Write only
    REG_NUM_CORES = 2'd2, // Read only
    REG_NUM_BANKS = 2'd3  // Read only
  } ctrl_reg_e;

  // Boot image held by the ROM
  localparam data_t BOOTROM_IMAGE [8] = '{
    32'hB007_0000,
    32'hB007_0001,
    32'hB007_0002,
    32'hB007_0003,
    32'hB007_0004,
    32'hB007_0005,
    32'hB007_0006,
    32'hB007_0007
  };

endpackage : mem_system_pkg

// File: mem_system_stimulus.txt
# op addr wdata strb | expected in the next cycle: rdata err eoc_valid wake_up (all hex)
# op is R read, W write or I idle
I 00000000 00000000 0 00000000 0 0 0
R 40000000 00000000 0 00000000 0 0 0
R 40000008 00000000 0 00000004 0 0 0
R 4000000C 00000000 0 00000004 0 0 0
R 40000004 00000000 0 00000000 0 0 0
W 80000000 11111111 F 00000000 0 0 0
W 80000004 22222222 F 00000000 0 0 0
W 80000008 33333333 F 00000000 0 0 0
W 8000000C 44444444 F 00000000 0 0 0
W 80000010 55555555 F 00000000 0 0 0
W 800003FC 66666666 F 00000000 0 0 0
R 80000000 00000000 0 11111111 0 0 0
R 80000004 00000000 0 22222222 0 0 0
R 80000008 00000000 0 33333333 0 0 0
R 8000000C 00000000 0 44444444 0 0 0
R 80000010 00000000 0 55555555 0 0 0
R 800003FC 00000000 0 66666666 0 0 0
W 80000004 AABBCCDD 5 00000000 0 0 0
W 80000008 AABBCCDD A 00000000 0 0 0
R 80000004 00000000 0 22BB22DD 0 0 0
R 80000008 00000000 0 AA33CC33 0 0 0
R A0000000 00000000 0 B0070000 0 0 0
R A0000004 00000000 0 B0070001 0 0 0
R A000001C 00000000 0 B0070007 0 0 0
W A0000008 DEADBEEF F 00000000 0 0 0
R A0000008 00000000 0 B0070002 0 0 0
W 40000000 00000001 F 00000000 0 1 0
R 40000000 00000000 0 00000001 0 1 0
W 40000000 A5A5A5A5 6 00000000 0 1 0
R 40000000 00000000 0 00A5A501 0 1 0
W 40000004 0000000B F 00000000 0 1 B
I 00000000 00000000 0 00000000 0 1 0
W 40000004 FFFFFFF5 F 00000000 0 1 5
R 40000004 00000000 0 00000000 0 1 0
R 00000000 00000000 0 00000000 1 1 0
W 80000400 CAFEF00D F 00000000 1 1 0
R A0000020 00000000 0 00000000 1 1 0
W 40000010 FFFFFFFF F 00000000 1 1 0
R 800003FC 00000000 0 66666666 0 1 0
R 80000400 00000000 0 00000000 1 1 0
W 40000000 00000000 1 00000000 0 0 0
R 40000000 00000000 0 00A5A500 0 0 0
I 00000000 00000000 0 00000000 0 0 0

// File: mem_system_sva.sv
/*
 * Memory system checks: response timing, error flag, wake pulse width, idle after reset
 */

`include "mem_system_macros.svh"

module mem_system_sva (
  input logic                     clk_i,
  input logic                     reset_i,
  input logic                     req_i,
  input logic                     resp_valid_o,
  input logic [`MS_DATA_W-1:0]    resp_rdata_o,
  input logic                     resp_err_o,
  input logic                     eoc_valid_o,
  input logic [`MS_NUM_CORES-1:0] wake_up_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // One response per request, one cycle later
  resp_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |=> resp_valid_o) else $error("resp_valid_o missing after a request");

  no_resp_without_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_i |=> !resp_valid_o) else $error("resp_valid_o without a request");

  err_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_err_o |-> resp_valid_o) else $error("resp_err_o outside a response");

  wake_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    (wake_up_o != '0) |=> (wake_up_o == '0)) else $error("wake_up_o held for two cycles");

  // Outputs idle right after reset is released
  idle_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (!resp_valid_o && !resp_err_o && !eoc_valid_o
                        && (resp_rdata_o == '0) && (wake_up_o == '0)))
    else $error("Outputs not idle after reset");

endmodule : mem_system_sva

bind mem_system mem_system_sva i_mem_system_sva (
  .clk_i       (clk_i       ),
  .reset_i     (reset_i     ),
  .req_i       (req_i       ),
  .resp_valid_o(resp_valid_o),
  .resp_rdata_o(resp_rdata_o),
  .resp_err_o  (resp_err_o  ),
  .eoc_valid_o (eoc_valid_o ),
  .wake_up_o   (wake_up_o   )
);

// File: periph_regs.sv
/*
 * Peripheral block: boot ROM and control registers for end of computation,
 * core wake-up and system configuration, with registered read data
 */

`include "mem_system_macros.svh"

module periph_regs
  import mem_system_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic                     is_rom_i,
  input  addr_t                    addr_i,
  input  data_t                    wdata_i,
  input  strb_t                    strb_i,
  output data_t                    rdata_o,
  output logic                     eoc_valid_o,
  output logic [`MS_NUM_CORES-1:0] wake_up_o
);

  localparam int unsigned WordLsb = $clog2(`MS_DATA_W / 8);
  localparam int unsigned RomIdxW = $clog2($size(BOOTROM_IMAGE));

  logic      [RomIdxW-1:0]       rom_idx;
  ctrl_reg_e                     reg_off;
  logic                          reg_we;
  data_t                         reg_rdata;
  data_t                         rdata_q;
  data_t                         eoc_q;
  logic      [`MS_NUM_CORES-1:0] wake_up_q;

  assign rom_idx = addr_i[WordLsb +: RomIdxW];
  assign reg_off = ctrl_reg_e'(addr_i[WordLsb +: $bits(ctrl_reg_e)]);
  assign reg_we  = req_i && we_i && !is_rom_i; // ROM writes are dropped

  // Register read view
  always_comb begin
    case (reg_off)
      REG_EOC:       reg_rdata = eoc_q;
      REG_WAKE_UP:   reg_rdata = '0;     // Write only
      REG_NUM_CORES: reg_rdata = data_t'(`MS_NUM_CORES);
      REG_NUM_BANKS: reg_rdata = data_t'(`MS_NUM_BANKS);
      default:       reg_rdata = '0;
    endcase
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
    end else begin
      wake_up_q <= '0; // Pulse lasts a single cycle
      if (reg_we && (reg_off == REG_EOC)) begin
        for (int unsigned i = 0; i < $bits(strb_t); i++) begin
          if (strb_i[i]) begin
            eoc_q[8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end
      if (reg_we && (reg_off == REG_WAKE_UP)) begin
        wake_up_q <= wdata_i[`MS_NUM_CORES-1:0]; // One bit per core
      end
    end
  end

  // Read data for the response cycle
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= is_rom_i ? BOOTROM_IMAGE[rom_idx] : reg_rdata;
    end
  end

  assign rdata_o     = rdata_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : periph_regs

// File: resp_mux.sv
/*
 * Response combiner: tracks each request for one cycle and merges
 * L2 and peripheral read data into a single response
 */

module resp_mux
  import mem_system_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    req_i,
  input  logic    we_i,
  input  target_e tgt_i,
  input  data_t   l2_rdata_i,
  input  data_t   periph_rdata_i,
  output logic    resp_valid_o,
  output data_t   resp_rdata_o,
  output logic    resp_err_o
);

  logic    valid_q;
  logic    read_q;
  target_e tgt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      read_q  <= 1'b0;
      tgt_q   <= TGT_NONE;
    end else begin
      valid_q <= req_i; // Every request is accepted
      if (req_i) begin
        read_q <= !we_i;
        tgt_q  <= tgt_i;
      end
    end
  end

  // Writes and misses return zero data
  always_comb begin
    resp_rdata_o = '0;
    if (valid_q && read_q) begin
      case (tgt_q)
        TGT_L2:             resp_rdata_o = l2_rdata_i;
        TGT_BOOTROM, TGT_CTRL: resp_rdata_o = periph_rdata_i;
        default:            resp_rdata_o = '0;
      endcase
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_err_o   = valid_q && (tgt_q == TGT_NONE);

endmodule : resp_mux

// File: run.sh
#!/bin/sh
# Build with Verilator and run from the project root
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_system -f compile.f -o sim_mem_system \
  && ./obj_dir/sim_mem_system | tee /dev/stderr | grep -q "Verification passed" \
  && echo "Simulation run: OK" \
  || { echo "Simulation run: FAILED"; exit 1; }

// File: tb_mem_system.sv
/*
 * Memory system testbench: replays the stimulus file and checks every response
 */

`include "mem_system_macros.svh"

module tb_mem_system;
  timeunit 1ns;
  timeprecision 1ps;

  localparam string StimFile     = "mem_system_stimulus.txt";
  localparam int    ResetCycles  = 4;
  localparam int    MarginCycles = 20;

  logic                     clk;
  logic                     reset;
  logic                     req;
  logic                     we;
  logic [`MS_ADDR_W-1:0]    addr;
  logic [`MS_DATA_W-1:0]    wdata;
  logic [`MS_DATA_W/8-1:0]  strb;
  logic                     resp_valid;
  logic [`MS_DATA_W-1:0]    resp_rdata;
  logic                     resp_err;
  logic                     eoc_valid;
  logic [`MS_NUM_CORES-1:0] wake_up;

  // One entry per stimulus line
  byte                      op_q[$];
  logic [`MS_ADDR_W-1:0]    addr_q[$];
  logic [`MS_DATA_W-1:0]    wdata_q[$];
  logic [`MS_DATA_W/8-1:0]  strb_q[$];
  logic [`MS_DATA_W-1:0]    rdata_q[$];
  logic                     err_q[$];
  logic                     eoc_q[$];
  logic [`MS_NUM_CORES-1:0] wake_q[$];

  int num_lines   = 0;
  int value_errs  = 0;
  int proto_errs  = 0;
  int cycle_cnt   = 0;
  int cycle_limit = ResetCycles + MarginCycles;
  bit loaded;

  mem_system i_dut (
    .clk_i       (clk       ),
    .reset_i     (reset     ),
    .req_i       (req       ),
    .we_i        (we        ),
    .addr_i      (addr      ),
    .wdata_i     (wdata     ),
    .strb_i      (strb      ),
    .resp_valid_o(resp_valid),
    .resp_rdata_o(resp_rdata),
    .resp_err_o  (resp_err  ),
    .eoc_valid_o (eoc_valid ),
    .wake_up_o   (wake_up   )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit from the length of the stimulus
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic load_stimulus(output bit ok);
    int                    fd;
    int                    code;
    string                 text;
    byte                   op;
    logic [31:0]           f_addr;
    logic [31:0]           f_wdata;
    logic [31:0]           f_strb;
    logic [31:0]           f_rdata;
    logic [31:0]           f_err;
    logic [31:0]           f_eoc;
    logic [31:0]           f_wake;
    ok = 1'b0;
    fd = $fopen(StimFile, "r");
    if (fd != 0) begin
      while ($fgets(text, fd) != 0) begin
        if (text.len() > 1 && text[0] != "#") begin // Skip comments and blank lines
          code = $sscanf(text, "%c %h %h %h %h %h %h %h", op, f_addr, f_wdata, f_strb,
                         f_rdata, f_err, f_eoc, f_wake);
          if (code == 8) begin
            op_q.push_back(op);
            addr_q.push_back(f_addr);
            wdata_q.push_back(f_wdata);
            strb_q.push_back(f_strb[`MS_DATA_W/8-1:0]);
            rdata_q.push_back(f_rdata);
            err_q.push_back(f_err[0]);
            eoc_q.push_back(f_eoc[0]);
            wake_q.push_back(f_wake[`MS_NUM_CORES-1:0]);
          end else begin
            $display("Stimulus line could not be parsed: %s", text);
            proto_errs++;
          end
        end
      end
      $fclose(fd);
      num_lines   = op_q.size();
      cycle_limit = num_lines + ResetCycles + MarginCycles;
      ok          = (num_lines > 0);
    end
  endtask

  task automatic apply_line(input int idx);
    req   = (op_q[idx] != "I");
    we    = (op_q[idx] == "W");
    addr  = addr_q[idx];
    wdata = wdata_q[idx];
    strb  = strb_q[idx];
  endtask

  task automatic compare_value(input string sig, input int step,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s at step %0d: expected %h, got %h", sig, step, expected, actual);
      value_errs++;
    end
  endtask

  // Responses and side outputs of line idx, one cycle after it was applied
  task automatic check_line(input int idx);
    bit exp_valid;
    exp_valid = (op_q[idx] != "I");
    if (exp_valid && !resp_valid) begin
      $display("Request at step %0d got no response in the next cycle", idx + 1);
      proto_errs++;
    end
    if (!exp_valid && resp_valid) begin
      $display("Response seen after idle step %0d with no request", idx + 1);
      proto_errs++;
    end
    compare_value("resp_rdata_o", idx + 1, rdata_q[idx], resp_rdata);
    compare_value("resp_err_o", idx + 1, 32'(err_q[idx]), 32'(resp_err));
    compare_value("eoc_valid_o", idx + 1, 32'(eoc_q[idx]), 32'(eoc_valid));
    compare_value("wake_up_o", idx + 1, 32'(wake_q[idx]), 32'(wake_up));
  endtask

  initial begin : main
    reset = 1'b1;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    strb  = '0;
    load_stimulus(loaded);
    if (!loaded) begin
      $display("Stimulus file %s is missing or holds no requests", StimFile);
      $display("Verification failed");
      $finish;
    end else begin
      repeat (ResetCycles) @(posedge clk);
      #1;
      reset = 1'b0;
      // Everything idle straight out of reset
      compare_value("resp_valid_o", 0, 32'h0, 32'(resp_valid));
      compare_value("resp_err_o", 0, 32'h0, 32'(resp_err));
      compare_value("eoc_valid_o", 0, 32'h0, 32'(eoc_valid));
      compare_value("wake_up_o", 0, 32'h0, 32'(wake_up));
      apply_line(0);
      for (int i = 1; i < num_lines; i++) begin
        @(posedge clk);
        #1;
        check_line(i - 1);
        apply_line(i);
      end
      @(posedge clk);
      #1;
      check_line(num_lines - 1);
      req = 1'b0;
      we  = 1'b0;
      $display("Done %0d steps: %0d value errors, %0d response errors",
               num_lines, value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule : tb_mem_system
